// ==== common/core_pkg.sv ====
package core_pkg;

   localparam int xpr_len = 32;
   localparam int reg_addr_width = 5;

   typedef logic [xpr_len-1:0] word_t;
   typedef logic [reg_addr_width-1:0] reg_addr_t;
   typedef logic [3:0] strb_t;
   typedef logic [2:0] mem_type_t;
   typedef logic [1:0] wb_src_t;

   // same codes as the load/store funct3 field
   localparam mem_type_t mem_b = 3'b000;
   localparam mem_type_t mem_h = 3'b001;
   localparam mem_type_t mem_w = 3'b010;
   localparam mem_type_t mem_bu = 3'b100;
   localparam mem_type_t mem_hu = 3'b101;

   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         reg_addr_t rs2;
         reg_addr_t rs1;
         logic [2:0] funct3;
         reg_addr_t rd;
         logic [6:0] opcode;
      } r;
      struct packed {
         logic [11:0] imm;
         reg_addr_t rs1;
         logic [2:0] funct3;
         reg_addr_t rd;
         logic [6:0] opcode;
      } i;
      struct packed {
         logic [6:0] imm_hi;
         reg_addr_t rs2;
         reg_addr_t rs1;
         logic [2:0] funct3;
         logic [4:0] imm_lo;
         logic [6:0] opcode;
      } s;
   } inst_t;

   localparam logic [6:0] op_lui = 7'b0110111;
   localparam logic [6:0] op_imm = 7'b0010011;
   localparam logic [6:0] op_reg = 7'b0110011;
   localparam logic [6:0] op_load = 7'b0000011;
   localparam logic [6:0] op_store = 7'b0100011;

   localparam logic [2:0] f3_add = 3'b000;
   localparam logic [2:0] f3_xor = 3'b100;
   localparam logic [2:0] f3_or = 3'b110;
   localparam logic [2:0] f3_and = 3'b111;
   localparam logic [6:0] funct7_base = 7'b0000000;
   localparam logic [6:0] funct7_sub = 7'b0100000;
   localparam logic [6:0] funct7_mul = 7'b0000001;

   localparam logic [3:0] alu_add = 4'd0;
   localparam logic [3:0] alu_sub = 4'd1;
   localparam logic [3:0] alu_and = 4'd2;
   localparam logic [3:0] alu_or = 4'd3;
   localparam logic [3:0] alu_xor = 4'd4;
   localparam logic [3:0] alu_lui = 4'd5;

   localparam wb_src_t wb_alu = 2'd0;
   localparam wb_src_t wb_mem = 2'd1;
   localparam wb_src_t wb_mul = 2'd2;

   // addi x0, x0, 0
   localparam word_t rv_nop = 32'h0000_0013;
   localparam word_t reset_pc = 32'h0000_0200;

   localparam int mul_count_width = $clog2(xpr_len);

   localparam int sb_depth = 4;
   localparam int sb_ptr_width = $clog2(sb_depth);
   localparam int sb_count_width = $clog2(sb_depth + 1);

endpackage

// ==== verilog/regfile.sv ====
`timescale 1ns/10ps

module regfile import core_pkg::*; (
   input  logic      clk,
   input  reg_addr_t ra1,
   input  reg_addr_t ra2,
   output word_t     rd1,
   output word_t     rd2,
   input  logic      wen,
   input  reg_addr_t wa,
   input  word_t     wd
);

   word_t regs [32];

   // x0 is never written
   always_ff @(posedge clk) begin
      if (wen && wa != '0) begin
         regs[wa] <= wd;
      end
   end

   assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
   assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// ==== verilog/mul_unit.sv ====
`timescale 1ns/10ps

module mul_unit import core_pkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  logic  req_valid,
   output logic  req_ready,
   input  word_t req_in_1,
   input  word_t req_in_2,
   output logic  resp_valid,
   output word_t resp_result
);

   logic busy;
   logic last_step;
   logic [mul_count_width-1:0] count;
   word_t multiplicand;
   word_t multiplier;
   word_t acc;

   assign req_ready = !busy;
   assign last_step = busy && count == '1;
   // acc stays put until the next request is taken
   assign resp_result = acc;

   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= 1'b0;
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= last_step;
         if (req_valid && !busy) begin
            busy <= 1'b1;
         end else if (last_step) begin
            busy <= 1'b0;
         end
      end
   end

   // one multiplier bit per cycle, low word only
   always_ff @(posedge clk) begin
      if (req_valid && !busy) begin
         multiplicand <= req_in_1;
         multiplier <= req_in_2;
         acc <= '0;
         count <= '0;
      end else if (busy) begin
         if (multiplier[0]) begin
            acc <= acc + multiplicand;
         end
         multiplicand <= multiplicand << 1;
         multiplier <= multiplier >> 1;
         count <= count + 1'b1;
      end
   end

endmodule

// ==== verilog/store_buffer.sv ====
`timescale 1ns/10ps

module store_buffer import core_pkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  logic  st_valid,
   output logic  st_ready,
   input  word_t st_addr,
   input  word_t st_data,
   input  strb_t st_strb,
   output logic  wr_valid,
   input  logic  wr_ready,
   output word_t wr_addr,
   output word_t wr_data,
   output strb_t wr_strb,
   output logic  pending
);

   word_t addr_q [sb_depth];
   word_t data_q [sb_depth];
   strb_t strb_q [sb_depth];
   logic [sb_ptr_width-1:0] wr_ptr;
   logic [sb_ptr_width-1:0] rd_ptr;
   logic [sb_count_width-1:0] count;
   logic push;
   logic pop;

   function automatic logic [sb_ptr_width-1:0] next_ptr(input logic [sb_ptr_width-1:0] ptr);
      return (ptr == sb_ptr_width'(sb_depth - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign st_ready = count != sb_count_width'(sb_depth);
   assign wr_valid = count != '0;
   assign pending = wr_valid;
   assign push = st_valid && st_ready;
   assign pop = wr_valid && wr_ready;

   // head entry shows straight away
   assign wr_addr = addr_q[rd_ptr];
   assign wr_data = data_q[rd_ptr];
   assign wr_strb = strb_q[rd_ptr];

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({push, pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         addr_q[wr_ptr] <= st_addr;
         data_q[wr_ptr] <= st_data;
         strb_q[wr_ptr] <= st_strb;
      end
   end

endmodule

// ==== pipeline/core_ctrl.sv ====
`timescale 1ns/10ps

module core_ctrl import core_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  inst_t      inst_DX,
   input  logic       imem_wait,
   input  logic       st_ready,
   input  logic       st_pending,
   input  logic       mul_req_ready,
   input  logic       mul_resp_valid,
   output logic       stall_IF,
   output logic       stall_DX,
   output logic       kill_IF,
   output logic [3:0] alu_funct,
   output logic       use_imm,
   output mem_type_t  mem_type,
   output logic       load_DX,
   output logic       store_DX,
   output logic       mul_req_valid,
   output logic       wr_reg_WB,
   output reg_addr_t  rd_WB,
   output wb_src_t    wb_src_WB,
   output logic       bypass_rs1,
   output logic       bypass_rs2
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic alu_f3_ok;
   logic is_lui;
   logic is_imm;
   logic is_reg;
   logic is_mul;
   logic is_load;
   logic is_store;
   logic uses_rs1;
   logic uses_rs2;
   logic wr_reg_DX;
   logic load_use;
   logic mul_issued;
   logic wait_r;
   logic held_valid;
   logic fetch_ok;

   assign opcode = inst_DX.r.opcode;
   assign funct3 = inst_DX.r.funct3;
   assign funct7 = inst_DX.r.funct7;
   assign mem_type = funct3;

   assign alu_f3_ok = funct3 inside {f3_add, f3_xor, f3_or, f3_and};
   assign is_lui = opcode == op_lui;
   assign is_imm = opcode == op_imm && alu_f3_ok;
   assign is_reg = opcode == op_reg && alu_f3_ok &&
                   (funct7 == funct7_base || (funct7 == funct7_sub && funct3 == f3_add));
   assign is_mul = opcode == op_reg && funct7 == funct7_mul && funct3 == f3_add;
   assign is_load = opcode == op_load && (funct3 inside {mem_b, mem_h, mem_w, mem_bu, mem_hu});
   assign is_store = opcode == op_store && (funct3 inside {mem_b, mem_h, mem_w});

   assign uses_rs1 = is_imm || is_reg || is_mul || is_load || is_store;
   assign uses_rs2 = is_reg || is_mul || is_store;
   // anything unsupported falls out with no write
   assign wr_reg_DX = (is_lui || is_imm || is_reg || is_mul || is_load) && inst_DX.r.rd != '0;
   assign use_imm = is_lui || is_imm || is_load || is_store;

   always_comb begin
      alu_funct = alu_add;
      if (is_lui) begin
         alu_funct = alu_lui;
      end else if (is_imm || is_reg) begin
         case (funct3)
            f3_xor: alu_funct = alu_xor;
            f3_or: alu_funct = alu_or;
            f3_and: alu_funct = alu_and;
            default: alu_funct = (is_reg && funct7 == funct7_sub) ? alu_sub : alu_add;
         endcase
      end
   end

   // rd_WB is never x0 while wr_reg_WB is set
   assign bypass_rs1 = wr_reg_WB && uses_rs1 && inst_DX.r.rs1 == rd_WB;
   assign bypass_rs2 = wr_reg_WB && uses_rs2 && inst_DX.r.rs2 == rd_WB;
   assign load_use = (bypass_rs1 || bypass_rs2) && wb_src_WB == wb_mem;

   assign stall_DX = load_use || (is_load && st_pending) || (is_store && !st_ready) ||
                     (is_mul && !mul_resp_valid);
   assign load_DX = is_load && !stall_DX;
   assign store_DX = is_store && !load_use;
   assign mul_req_valid = is_mul && !mul_issued && !load_use;

   // word for PC_IF is either arriving now or held from an earlier cycle
   assign fetch_ok = !wait_r || held_valid;
   assign kill_IF = !fetch_ok;
   assign stall_IF = stall_DX || !fetch_ok;

   always_ff @(posedge clk) begin
      if (reset) begin
         wait_r <= 1'b1;
         held_valid <= 1'b0;
         mul_issued <= 1'b0;
         wr_reg_WB <= 1'b0;
      end else begin
         wait_r <= imem_wait;
         held_valid <= stall_IF && fetch_ok;
         if (mul_resp_valid) begin
            mul_issued <= 1'b0;
         end else if (mul_req_valid && mul_req_ready) begin
            mul_issued <= 1'b1;
         end
         wr_reg_WB <= wr_reg_DX && !stall_DX;
      end
   end

   always_ff @(posedge clk) begin
      rd_WB <= inst_DX.r.rd;
      wb_src_WB <= is_load ? wb_mem : (is_mul ? wb_mul : wb_alu);
   end

endmodule

// ==== pipeline/core_pipeline.sv ====
`timescale 1ns/10ps

module core_pipeline import core_pkg::*; (
   input  logic  clk,
   input  logic  reset,
   output word_t imem_addr,
   input  word_t imem_rdata,
   input  logic  imem_wait,
   output logic  dmem_en,
   output word_t dmem_addr,
   input  word_t dmem_rdata,
   output logic  st_valid,
   input  logic  st_ready,
   output word_t st_addr,
   output word_t st_data,
   output strb_t st_strb,
   input  logic  st_pending
);

   word_t PC_IF;
   word_t held_word;
   logic imem_wait_r;
   word_t fetch_word;
   inst_t inst_DX;

   logic stall_IF;
   logic stall_DX;
   logic kill_IF;
   logic [3:0] alu_funct;
   logic use_imm;
   mem_type_t mem_type;
   logic load_DX;
   logic store_DX;
   logic bypass_rs1;
   logic bypass_rs2;

   logic mul_req_valid;
   logic mul_req_ready;
   logic mul_resp_valid;
   word_t mul_resp_result;

   word_t rs1_data;
   word_t rs2_data;
   word_t rs1_byp;
   word_t rs2_byp;
   word_t imm;
   word_t alu_b;
   word_t alu_out;

   logic wr_reg_WB;
   reg_addr_t rd_WB;
   wb_src_t wb_src_WB;
   word_t alu_out_WB;
   mem_type_t mem_type_WB;
   word_t shifted_WB;
   word_t load_data_WB;
   word_t wb_data_WB;

   core_ctrl ctrl (
      .clk(clk),
      .reset(reset),
      .inst_DX(inst_DX),
      .imem_wait(imem_wait),
      .st_ready(st_ready),
      .st_pending(st_pending),
      .mul_req_ready(mul_req_ready),
      .mul_resp_valid(mul_resp_valid),
      .stall_IF(stall_IF),
      .stall_DX(stall_DX),
      .kill_IF(kill_IF),
      .alu_funct(alu_funct),
      .use_imm(use_imm),
      .mem_type(mem_type),
      .load_DX(load_DX),
      .store_DX(store_DX),
      .mul_req_valid(mul_req_valid),
      .wr_reg_WB(wr_reg_WB),
      .rd_WB(rd_WB),
      .wb_src_WB(wb_src_WB),
      .bypass_rs1(bypass_rs1),
      .bypass_rs2(bypass_rs2)
   );

   // a stalled fetch asks for the same word again
   assign imem_addr = stall_IF ? PC_IF : PC_IF + 32'd4;

   always_ff @(posedge clk) begin
      if (reset) begin
         PC_IF <= reset_pc;
         imem_wait_r <= 1'b1;
      end else begin
         PC_IF <= imem_addr;
         imem_wait_r <= imem_wait;
      end
   end

   always_ff @(posedge clk) begin
      if (!imem_wait_r) begin
         held_word <= imem_rdata;
      end
   end

   assign fetch_word = imem_wait_r ? held_word : imem_rdata;

   always_ff @(posedge clk) begin
      if (reset) begin
         inst_DX <= rv_nop;
      end else if (!stall_DX) begin
         inst_DX <= kill_IF ? rv_nop : fetch_word;
      end
   end

   regfile rf (
      .clk(clk),
      .ra1(inst_DX.r.rs1),
      .ra2(inst_DX.r.rs2),
      .rd1(rs1_data),
      .rd2(rs2_data),
      .wen(wr_reg_WB),
      .wa(rd_WB),
      .wd(wb_data_WB)
   );

   assign rs1_byp = bypass_rs1 ? wb_data_WB : rs1_data;
   assign rs2_byp = bypass_rs2 ? wb_data_WB : rs2_data;

   always_comb begin
      if (alu_funct == alu_lui) begin
         imm = {inst_DX.i.imm, inst_DX.i.rs1, inst_DX.i.funct3, 12'b0};
      end else if (inst_DX.s.opcode == op_store) begin
         imm = {{20{inst_DX.s.imm_hi[6]}}, inst_DX.s.imm_hi, inst_DX.s.imm_lo};
      end else begin
         imm = {{20{inst_DX.i.imm[11]}}, inst_DX.i.imm};
      end
   end

   assign alu_b = use_imm ? imm : rs2_byp;

   always_comb begin
      case (alu_funct)
         alu_sub: alu_out = rs1_byp - alu_b;
         alu_and: alu_out = rs1_byp & alu_b;
         alu_or: alu_out = rs1_byp | alu_b;
         alu_xor: alu_out = rs1_byp ^ alu_b;
         alu_lui: alu_out = alu_b;
         default: alu_out = rs1_byp + alu_b;
      endcase
   end

   mul_unit mul (
      .clk(clk),
      .reset(reset),
      .req_valid(mul_req_valid),
      .req_ready(mul_req_ready),
      .req_in_1(rs1_byp),
      .req_in_2(rs2_byp),
      .resp_valid(mul_resp_valid),
      .resp_result(mul_resp_result)
   );

   assign dmem_en = load_DX;
   assign dmem_addr = {alu_out[31:2], 2'b00};

   // source lane replicated, strobe picks the bytes
   assign st_valid = store_DX;
   assign st_addr = {alu_out[31:2], 2'b00};

   always_comb begin
      case (mem_type)
         mem_b: begin
            st_data = {4{rs2_byp[7:0]}};
            st_strb = 4'b0001 << alu_out[1:0];
         end
         mem_h: begin
            st_data = {2{rs2_byp[15:0]}};
            st_strb = alu_out[1] ? 4'b1100 : 4'b0011;
         end
         default: begin
            st_data = rs2_byp;
            st_strb = 4'b1111;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      alu_out_WB <= alu_out;
      mem_type_WB <= mem_type;
   end

   assign shifted_WB = dmem_rdata >> {alu_out_WB[1:0], 3'b000};

   always_comb begin
      case (mem_type_WB)
         mem_b: load_data_WB = {{24{shifted_WB[7]}}, shifted_WB[7:0]};
         mem_h: load_data_WB = {{16{shifted_WB[15]}}, shifted_WB[15:0]};
         mem_bu: load_data_WB = {24'b0, shifted_WB[7:0]};
         mem_hu: load_data_WB = {16'b0, shifted_WB[15:0]};
         default: load_data_WB = shifted_WB;
      endcase
   end

   always_comb begin
      case (wb_src_WB)
         wb_mem: wb_data_WB = load_data_WB;
         wb_mul: wb_data_WB = mul_resp_result;
         default: wb_data_WB = alu_out_WB;
      endcase
   end

endmodule

// ==== verilog/core_top.sv ====
`timescale 1ns/10ps

module core_top import core_pkg::*; (
   input  logic  clk,
   input  logic  reset,
   output word_t imem_addr,
   input  word_t imem_rdata,
   input  logic  imem_wait,
   output logic  dmem_en,
   output word_t dmem_addr,
   input  word_t dmem_rdata,
   output logic  wr_valid,
   input  logic  wr_ready,
   output word_t wr_addr,
   output word_t wr_data,
   output strb_t wr_strb
);

   logic st_valid;
   logic st_ready;
   word_t st_addr;
   word_t st_data;
   strb_t st_strb;
   logic st_pending;

   core_pipeline pipeline (
      .clk(clk),
      .reset(reset),
      .imem_addr(imem_addr),
      .imem_rdata(imem_rdata),
      .imem_wait(imem_wait),
      .dmem_en(dmem_en),
      .dmem_addr(dmem_addr),
      .dmem_rdata(dmem_rdata),
      .st_valid(st_valid),
      .st_ready(st_ready),
      .st_addr(st_addr),
      .st_data(st_data),
      .st_strb(st_strb),
      .st_pending(st_pending)
   );

   // stores drain to the data memory write port in order
   store_buffer sbuf (
      .clk(clk),
      .reset(reset),
      .st_valid(st_valid),
      .st_ready(st_ready),
      .st_addr(st_addr),
      .st_data(st_data),
      .st_strb(st_strb),
      .wr_valid(wr_valid),
      .wr_ready(wr_ready),
      .wr_addr(wr_addr),
      .wr_data(wr_data),
      .wr_strb(wr_strb),
      .pending(st_pending)
   );

endmodule

// ==== dv/core_tb.sv ====
`timescale 1ns/10ps

module core_tb import core_pkg::*; ();

   logic clk = 1'b0;
   logic reset;
   word_t imem_addr;
   word_t imem_rdata;
   logic imem_wait;
   logic dmem_en;
   word_t dmem_addr;
   word_t dmem_rdata;
   logic wr_valid;
   logic wr_ready;
   word_t wr_addr;
   word_t wr_data;
   strb_t wr_strb;

   word_t prog [256];
   word_t mem [4096];
   int pc_n;
   logic [15:0] lfsr = 16'd44;
   logic ready_hold = 1'b0;
   word_t seen_addr [$];
   word_t seen_data [$];
   strb_t seen_strb [$];
   int value_errs = 0;
   int other_errs = 0;

   core_top uut (.*);

   always #5 clk = ~clk;

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   always @(posedge clk) begin
      lfsr = lfsr_next(lfsr);
      imem_wait <= lfsr[0];
      lfsr = lfsr_next(lfsr);
      wr_ready <= ready_hold ? 1'b0 : lfsr[0];
   end

   // instruction memory answers one cycle later and has no data for a waited address
   always @(posedge clk) begin
      word_t idx;
      idx = (imem_addr - reset_pc) >> 2;
      if (imem_wait) begin
         imem_rdata <= 'x;
      end else begin
         imem_rdata <= (idx < 256) ? prog[idx] : rv_nop;
      end
   end

   always @(posedge clk) begin
      if (dmem_en) begin
         dmem_rdata <= mem[dmem_addr[13:2]];
      end
      if (wr_valid && wr_ready) begin
         for (int b = 0; b < 4; b++) begin
            if (wr_strb[b]) begin
               mem[wr_addr[13:2]][8*b +: 8] <= wr_data[8*b +: 8];
            end
         end
         seen_addr.push_back(wr_addr);
         seen_data.push_back(wr_data);
         seen_strb.push_back(wr_strb);
      end
   end

   function automatic word_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
      return {f7, rs2, rs1, f3, rd, op_reg};
   endfunction

   function automatic word_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic word_t s_type(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
   endfunction

   task automatic emit(input word_t w);
      prog[pc_n] = w;
      pc_n++;
   endtask

   // lui plus addi with the upper part rounded for the signed low immediate
   task automatic emit_li(input reg_addr_t rd, input word_t v);
      word_t upper;
      upper = v + 32'h800;
      emit({upper[31:12], rd, op_lui});
      emit(i_type(v[11:0], rd, f3_add, rd, op_imm));
   endtask

   task automatic begin_test(input logic hold);
      ready_hold = hold;
      @(posedge clk);
      reset <= 1'b1;
      pc_n = 0;
      for (int i = 0; i < 256; i++) begin
         prog[i] = rv_nop;
      end
      for (int i = 0; i < 4096; i++) begin
         mem[i] = {i[11:0] ^ 12'hA5C, 8'h3C, i[11:0]};
      end
      seen_addr.delete();
      seen_data.delete();
      seen_strb.delete();
   endtask

   task automatic release_reset();
      repeat (4) @(posedge clk);
      reset <= 1'b0;
   endtask

   task automatic wait_stores(input int n);
      int cycles;
      cycles = 0;
      while (seen_addr.size() < n && cycles < 5000) begin
         @(negedge clk);
         cycles++;
      end
      if (seen_addr.size() < n) begin
         other_errs++;
         $display("timeout: only %0d of %0d stores reached memory", seen_addr.size(), n);
      end
   endtask

   task automatic check_word(input string what, input word_t got, input word_t exp);
      if (got !== exp) begin
         value_errs++;
         $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_store(input word_t addr, input word_t data, input strb_t strb);
      word_t a;
      word_t d;
      strb_t s;
      if (seen_addr.size() == 0) begin
         other_errs++;
         $display("missing store: no write arrived for address %h", addr);
      end else begin
         a = seen_addr.pop_front();
         d = seen_data.pop_front();
         s = seen_strb.pop_front();
         if (a !== addr || d !== data || s !== strb) begin
            value_errs++;
            $display("Fail at %0t: store %h/%h/%b expected %h/%h/%b",
                     $time, a, d, s, addr, data, strb);
         end
      end
   endtask

   task automatic check_no_more();
      if (seen_addr.size() != 0) begin
         other_errs++;
         $display("unexpected extra stores: %0d more than the program issues", seen_addr.size());
      end
   endtask

   task automatic test_alu_bypass();
      word_t x1;
      word_t x2;
      word_t x3;
      word_t x4;
      word_t x5;
      word_t x6;
      word_t x7;
      word_t x8;
      word_t x9;
      begin_test(1'b0);
      emit({20'h12345, 5'd1, op_lui});
      emit(i_type(12'h678, 5'd1, f3_add, 5'd2, op_imm));
      emit(i_type(12'hFFB, 5'd2, f3_add, 5'd3, op_imm));
      emit(r_type(funct7_base, 5'd3, 5'd2, f3_add, 5'd4));
      emit(r_type(funct7_sub, 5'd1, 5'd4, f3_add, 5'd5));
      emit(r_type(funct7_base, 5'd2, 5'd5, f3_and, 5'd6));
      emit(r_type(funct7_base, 5'd3, 5'd6, f3_or, 5'd7));
      emit(r_type(funct7_base, 5'd4, 5'd7, f3_xor, 5'd8));
      emit(i_type(12'h8F0, 5'd8, f3_xor, 5'd9, op_imm));
      emit(i_type(12'h700, 5'd9, f3_or, 5'd9, op_imm));
      emit(i_type(12'h7F3, 5'd9, f3_and, 5'd9, op_imm));
      emit({20'h00001, 5'd20, op_lui});
      emit(s_type(12'd8, 5'd8, 5'd20, mem_w));
      emit(s_type(12'd12, 5'd9, 5'd20, mem_w));
      release_reset();
      x1 = 32'h1234_5000;
      x2 = x1 + 32'h678;
      x3 = x2 - 32'd5;
      x4 = x2 + x3;
      x5 = x4 - x1;
      x6 = x5 & x2;
      x7 = x6 | x3;
      x8 = x7 ^ x4;
      x9 = ((x8 ^ 32'hFFFF_F8F0) | 32'h700) & 32'h7F3;
      wait_stores(2);
      check_store(32'h1008, x8, 4'b1111);
      check_store(32'h100C, x9, 4'b1111);
      check_no_more();
   endtask

   task automatic test_store_lanes();
      word_t v;
      v = 32'hA1B2_C3D4;
      begin_test(1'b0);
      emit_li(5'd1, 32'h1000);
      emit_li(5'd2, v);
      for (int k = 0; k < 4; k++) begin
         emit(s_type(12'(k), 5'd2, 5'd1, mem_b));
      end
      emit(s_type(12'd0, 5'd2, 5'd1, mem_h));
      emit(s_type(12'd2, 5'd2, 5'd1, mem_h));
      release_reset();
      wait_stores(6);
      for (int k = 0; k < 4; k++) begin
         check_store(32'h1000, {4{v[7:0]}}, strb_t'(4'b0001 << k));
      end
      check_store(32'h1000, {2{v[15:0]}}, 4'b0011);
      check_store(32'h1000, {2{v[15:0]}}, 4'b1100);
      check_no_more();
   endtask

   function automatic word_t expected_load(input word_t w, input logic [2:0] f3, input int off);
      word_t sh;
      sh = w >> (8 * off);
      case (f3)
         3'b000: return {{24{sh[7]}}, sh[7:0]};
         3'b100: return {24'b0, sh[7:0]};
         3'b001: return {{16{sh[15]}}, sh[15:0]};
         3'b101: return {16'b0, sh[15:0]};
         default: return w;
      endcase
   endfunction

   task automatic test_load_extend();
      logic [2:0] f3s [13];
      int offs [13];
      word_t src;
      f3s = '{0, 0, 0, 0, 4, 4, 4, 4, 1, 1, 5, 5, 2};
      offs = '{0, 1, 2, 3, 0, 1, 2, 3, 0, 2, 0, 2, 0};
      src = 32'h80F1_7F8E;
      begin_test(1'b0);
      mem[32'h1000 >> 2] = src;
      emit_li(5'd1, 32'h1000);
      emit_li(5'd20, 32'h2000);
      // each store reads the load result straight away
      for (int k = 0; k < 13; k++) begin
         emit(i_type(12'(offs[k]), 5'd1, f3s[k], 5'd5, op_load));
         emit(s_type(12'(4 * k), 5'd5, 5'd20, mem_w));
      end
      release_reset();
      wait_stores(13);
      for (int k = 0; k < 13; k++) begin
         check_store(32'h2000 + 4 * k, expected_load(src, f3s[k], offs[k]), 4'b1111);
      end
      check_no_more();
   endtask

   task automatic test_multiply();
      word_t a [4];
      word_t b [4];
      a = '{32'd7, 32'hFFFF_FFFD, 32'h1234_5678, 32'hFFFF_FFFF};
      b = '{32'd6, 32'd5, 32'h9ABC_DEF0, 32'hFFFF_FFFF};
      begin_test(1'b0);
      emit_li(5'd20, 32'h3000);
      for (int k = 0; k < 4; k++) begin
         emit_li(5'd1, a[k]);
         emit_li(5'd2, b[k]);
         emit(r_type(funct7_mul, 5'd2, 5'd1, f3_add, 5'd3));
         emit(r_type(funct7_base, 5'd1, 5'd3, f3_add, 5'd4));
         emit(s_type(12'(8 * k), 5'd3, 5'd20, mem_w));
         emit(s_type(12'(8 * k + 4), 5'd4, 5'd20, mem_w));
      end
      release_reset();
      wait_stores(8);
      for (int k = 0; k < 4; k++) begin
         check_store(32'h3000 + 8 * k, a[k] * b[k], 4'b1111);
         check_store(32'h3000 + 8 * k + 4, a[k] * b[k] + a[k], 4'b1111);
      end
      check_no_more();
   endtask

   task automatic test_store_order();
      word_t vals [6];
      int cycles;
      int bad_cycles;
      begin_test(1'b1);
      emit_li(5'd20, 32'h1000);
      for (int k = 0; k < 6; k++) begin
         vals[k] = 32'h5A00_0011 * (k + 3);
         emit_li(reg_addr_t'(k + 1), vals[k]);
      end
      for (int k = 0; k < 6; k++) begin
         emit(s_type(12'(4 * k), reg_addr_t'(k + 1), 5'd20, mem_w));
      end
      emit(i_type(12'd8, 5'd20, mem_w, 5'd7, op_load));
      emit(s_type(12'h40, 5'd7, 5'd20, mem_w));
      release_reset();
      cycles = 0;
      while (!wr_valid && cycles < 500) begin
         @(negedge clk);
         cycles++;
      end
      if (!wr_valid) begin
         other_errs++;
         $display("timeout: no store reached the write port within %0d cycles", cycles);
      end else begin
         // memory port held off so the buffer fills and DX stalls behind it
         bad_cycles = 0;
         repeat (60) begin
            @(negedge clk);
            if (!wr_valid || dmem_en) begin
               bad_cycles++;
            end
         end
         if (bad_cycles != 0) begin
            other_errs++;
            $display("held write port lost its entry or a load issued in %0d cycles",
                     bad_cycles);
         end
         check_word("head address", wr_addr, 32'h1000);
         check_word("head data", wr_data, vals[0]);
      end
      ready_hold = 1'b0;
      wait_stores(7);
      for (int k = 0; k < 6; k++) begin
         check_store(32'h1000 + 4 * k, vals[k], 4'b1111);
      end
      check_store(32'h1040, vals[2], 4'b1111);
      check_no_more();
      @(negedge clk);
      check_word("memory at 1040", mem[32'h1040 >> 2], vals[2]);
   endtask

   initial begin
      reset = 1'b1;
      imem_wait = 1'b0;
      wr_ready = 1'b0;
      imem_rdata = rv_nop;
      dmem_rdata = '0;
      test_alu_bypass();
      test_store_lanes();
      test_load_extend();
      test_multiply();
      test_store_order();
      $display("errors: %0d wrong values, %0d other", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
common/core_pkg.sv
verilog/regfile.sv
verilog/mul_unit.sv
verilog/store_buffer.sv
pipeline/core_ctrl.sv
pipeline/core_pipeline.sv
verilog/core_top.sv
dv/core_tb.sv

// ==== Bender.yml ====
package:
  name: core

sources:
  - common/core_pkg.sv
  - verilog/regfile.sv
  - verilog/mul_unit.sv
  - verilog/store_buffer.sv
  - pipeline/core_ctrl.sv
  - pipeline/core_pipeline.sv
  - verilog/core_top.sv
  - target: test
    files:
      - dv/core_tb.sv
